/* compile.f */
mips_pkg.sv
inst_decoder.sv
operand_forward.sv
reg_file.sv
alu.sv
exec_stage.sv
mips_core.sv
mips_core_asserts.sv
tb_mips_core.sv

/* Bender.yml */
package:
  name: mips_core

sources:
  - mips_pkg.sv
  - inst_decoder.sv
  - operand_forward.sv
  - reg_file.sv
  - alu.sv
  - exec_stage.sv
  - mips_core.sv
  - target: test
    files:
      - mips_core_asserts.sv
      - tb_mips_core.sv

/* tb_mips_core.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_mips_core;
    import mips_pkg::*;

    typedef struct packed {
        reg_addr_t addr;
        word_t     data;
        int        due;                               // cycle count when wb is visible
    } wb_entry_t;

    logic      clk_i = 1'b0;
    logic      rst_n_i;
    logic      inst_valid_i;
    word_t     inst_i;
    logic      wb_we_o;
    reg_addr_t wb_waddr_o;
    word_t     wb_wdata_o;

    word_t     mregs [32];                            // architectural model
    wb_entry_t exp_q [$];
    wb_entry_t head;
    reg_addr_t last_dst;
    logic      due_now;
    int        cyc = 0;
    int        checks = 0;
    int        errors = 0;

    mips_core u_mips_core (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .wb_we_o      (wb_we_o),
        .wb_waddr_o   (wb_waddr_o),
        .wb_wdata_o   (wb_wdata_o)
    );

    always #10 clk_i = ~clk_i;

    always @(posedge clk_i)
    begin
        cyc <= cyc + 1;
    end

    function automatic word_t r_type(input reg_addr_t rs, input reg_addr_t rt,
                                     input reg_addr_t rd, input logic [4:0] sa,
                                     input logic [5:0] fn);
        return {6'b000000, rs, rt, rd, sa, fn};
    endfunction

    function automatic word_t i_type(input opcode_e op, input reg_addr_t rs,
                                     input reg_addr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // dense dependencies, mostly r0-r7
    function automatic reg_addr_t pick_reg();
        if ($urandom_range(0, 7) != 0)
            return reg_addr_t'($urandom_range(0, 7));
        return reg_addr_t'($urandom_range(0, 31));
    endfunction

    function automatic word_t dropped_inst(input reg_addr_t rs, input reg_addr_t rt,
                                           input reg_addr_t rd);
        case ($urandom_range(0, 3))
            0:       return r_type(rs, rt, REG_ZERO, 5'd0, 6'b011000);        // mult
            1:       return r_type(REG_ZERO, REG_ZERO, rd, 5'd0, 6'b010000);  // mfhi
            2:       return r_type(rs, rt, rd, 5'd0, 6'b001010);              // movz
            default: return {6'b100011, rs, rt, 16'h0010};                    // lw
        endcase
    endfunction

    // cls 0 logic, 1 shift, 2 arith, 3 dependent mix, 4 no-write mix
    function automatic word_t rand_inst(input int cls);
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   rd;
        logic [4:0]  sa;
        logic [15:0] imm;
        int          kind;
        rs  = pick_reg();
        rt  = pick_reg();
        rd  = pick_reg();
        sa  = 5'($urandom_range(0, 31));
        imm = 16'($urandom);
        if ($urandom_range(0, 3) == 0)
            imm[15] = 1'b1;
        if (cls == 3 && $urandom_range(0, 1) == 1)
        begin
            rs = last_dst;                            // both operands on previous result
            rt = last_dst;
        end
        if ($urandom_range(0, 19) == 0 || (cls == 4 && $urandom_range(0, 1) == 1))
            return dropped_inst(rs, rt, rd);
        if (cls == 4)
        begin
            rd = REG_ZERO;
            rt = REG_ZERO;
        end
        case (cls)
            0:       kind = $urandom_range(0, 7);
            1:       kind = $urandom_range(8, 13);
            2:       kind = $urandom_range(14, 23);
            default: kind = $urandom_range(0, 23);
        endcase
        case (kind)
            0:       return r_type(rs, rt, rd, 5'd0, FN_OR);
            1:       return r_type(rs, rt, rd, 5'd0, FN_AND);
            2:       return r_type(rs, rt, rd, 5'd0, FN_XOR);
            3:       return r_type(rs, rt, rd, 5'd0, FN_NOR);
            4:       return i_type(OP_ORI, rs, rt, imm);
            5:       return i_type(OP_ANDI, rs, rt, imm);
            6:       return i_type(OP_XORI, rs, rt, imm);
            7:       return i_type(OP_LUI, rs, rt, imm);
            8:       return r_type(REG_ZERO, rt, rd, sa, FN_SLL);
            9:       return r_type(REG_ZERO, rt, rd, sa, FN_SRL);
            10:      return r_type(REG_ZERO, rt, rd, sa, FN_SRA);
            11:      return r_type(rs, rt, rd, 5'd0, FN_SLLV);
            12:      return r_type(rs, rt, rd, 5'd0, FN_SRLV);
            13:      return r_type(rs, rt, rd, 5'd0, FN_SRAV);
            14:      return r_type(rs, rt, rd, 5'd0, FN_ADD);
            15:      return r_type(rs, rt, rd, 5'd0, FN_ADDU);
            16:      return r_type(rs, rt, rd, 5'd0, FN_SUB);
            17:      return r_type(rs, rt, rd, 5'd0, FN_SUBU);
            18:      return r_type(rs, rt, rd, 5'd0, FN_SLT);
            19:      return r_type(rs, rt, rd, 5'd0, FN_SLTU);
            20:      return i_type(OP_ADDI, rs, rt, imm);
            21:      return i_type(OP_ADDIU, rs, rt, imm);
            22:      return i_type(OP_SLTI, rs, rt, imm);
            default: return i_type(OP_SLTIU, rs, rt, imm);
        endcase
    endfunction

    task automatic model_exec(input word_t inst, output logic we, output reg_addr_t dst,
                              output word_t val);
        word_t      a;
        word_t      b;
        word_t      simm;
        logic [4:0] sa;
        a    = mregs[inst[25:21]];
        b    = mregs[inst[20:16]];
        simm = {{16{inst[15]}}, inst[15:0]};
        sa   = inst[10:6];
        we   = 1'b1;
        dst  = inst[20:16];
        val  = '0;
        if (inst[31:26] == OP_SPECIAL)
        begin
            dst = inst[15:11];
            case (inst[5:0])
                FN_OR:           val = a | b;
                FN_AND:          val = a & b;
                FN_XOR:          val = a ^ b;
                FN_NOR:          val = ~(a | b);
                FN_SLL:          val = b << sa;
                FN_SRL:          val = b >> sa;
                FN_SRA:          val = $signed(b) >>> sa;
                FN_SLLV:         val = b << a[4:0];
                FN_SRLV:         val = b >> a[4:0];
                FN_SRAV:         val = $signed(b) >>> a[4:0];
                FN_ADD, FN_ADDU: val = a + b;         // no trap on overflow
                FN_SUB, FN_SUBU: val = a - b;
                FN_SLT:          val = word_t'($signed(a) < $signed(b));
                FN_SLTU:         val = word_t'(a < b);
                default:         we = 1'b0;
            endcase
        end
        else
        begin
            case (inst[31:26])
                OP_ORI:            val = a | {16'h0000, inst[15:0]};
                OP_ANDI:           val = a & {16'h0000, inst[15:0]};
                OP_XORI:           val = a ^ {16'h0000, inst[15:0]};
                OP_LUI:            val = a | {inst[15:0], 16'h0000};
                OP_ADDI, OP_ADDIU: val = a + simm;
                OP_SLTI:           val = word_t'($signed(a) < $signed(simm));
                OP_SLTIU:          val = word_t'(a < simm);   // unsigned compare
                default:           we = 1'b0;
            endcase
        end
        if (dst == REG_ZERO)
            we = 1'b0;
        if (we)
            mregs[dst] = val;
    endtask

    task automatic issue(input logic valid, input word_t inst);
        logic      we;
        reg_addr_t dst;
        word_t     val;
        wb_entry_t entry;
        @(posedge clk_i);
        inst_valid_i <= valid;
        inst_i       <= inst;
        if (valid)
        begin
            model_exec(inst, we, dst, val);
            if (we)
            begin
                entry.addr = dst;
                entry.data = val;
                entry.due  = cyc + 3;                 // sampled next edge, wb two edges on
                exp_q.push_back(entry);
                last_dst = dst;
            end
        end
    endtask

    // cls below zero gives idle slots only
    task automatic run_test(input string name, input int cls, input int count);
        int err0;
        int chk0;
        int waits;
        err0 = errors;
        chk0 = checks;
        for (int i = 0; i < count; i++)
        begin
            if (cls < 0 || $urandom_range(0, 9) == 0)
                issue(1'b0, rand_inst(cls));
            else
                issue(1'b1, rand_inst(cls));
        end
        waits = 0;
        while (exp_q.size() != 0 && waits < 10)
        begin
            issue(1'b0, '0);
            waits++;
        end
        if (exp_q.size() != 0)
        begin
            $display("test %s: %0d expected writebacks never appeared before the timeout",
                     name, exp_q.size());
            errors++;
            exp_q.delete();
        end
        repeat (3) issue(1'b0, '0);                   // catch stray pulses in this test
        $display("test %s done: %0d checks, %0d errors", name, checks - chk0,
                 errors - err0);
    endtask

    always @(negedge clk_i)
    begin
        if (rst_n_i)
        begin
            due_now = (exp_q.size() != 0) && (exp_q[0].due == cyc);
            checks++;
            if (wb_we_o !== due_now)
            begin
                $display("ERROR %0t: wb_we_o is %b, expected %b", $time, wb_we_o, due_now);
                errors++;
            end
            if (due_now)
            begin
                head = exp_q.pop_front();
                if (wb_waddr_o !== head.addr || wb_wdata_o !== head.data)
                begin
                    $display("ERROR %0t: writeback r%0d = %h, expected r%0d = %h", $time,
                             wb_waddr_o, wb_wdata_o, head.addr, head.data);
                    errors++;
                end
            end
        end
    end

    initial
    begin
        void'($urandom(66655));
        rst_n_i      = 1'b0;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        last_dst     = REG_ZERO;
        for (int r = 0; r < 32; r++)
        begin
            mregs[r] = '0;
        end
        repeat (5) @(posedge clk_i);
        rst_n_i <= 1'b1;
        run_test("reset_quiet", -1, 8);
        run_test("logic", 0, 200);
        run_test("shift", 1, 200);
        run_test("arith", 2, 200);
        run_test("forward", 3, 300);
        run_test("no_write", 4, 100);
        errors += u_mips_core.u_mips_core_asserts.fail_count;   // bound assertion failures
        $display("tests 6, checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* mips_core_asserts.sv */
`timescale 1ns/100ps
`default_nettype none

module mips_core_asserts (
    input  wire                      clk_i,
    input  wire                      rst_n_i,
    input  wire                      inst_valid_i,
    input  wire                      dec_wreg_i,
    input  wire                      wb_we_i,
    input  wire mips_pkg::reg_addr_t wb_waddr_i
);
    import mips_pkg::*;

    int fail_count = 0;

    // checked mid-cycle, flops are cleared by then
    a_quiet_in_reset: assert property (@(negedge clk_i) !rst_n_i |-> !wb_we_i)
    else
    begin
        $error("writeback pulse while in reset");
        fail_count++;
    end

    a_no_r0_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_we_i |-> (wb_waddr_i != REG_ZERO))
    else
    begin
        $error("writeback to r0");
        fail_count++;
    end

    a_wb_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (inst_valid_i && dec_wreg_i) |-> ##2 wb_we_i)
    else
    begin
        $error("writing instruction gave no writeback two cycles later");
        fail_count++;
    end

    a_wb_has_source: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_we_i |-> $past(dec_wreg_i, 2))
    else
    begin
        $error("writeback without a writing instruction");
        fail_count++;
    end

endmodule

bind mips_core mips_core_asserts u_mips_core_asserts (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .inst_valid_i (inst_valid_i),
    .dec_wreg_i   (dec_wreg),
    .wb_we_i      (wb_we_o),
    .wb_waddr_i   (wb_waddr_o)
);

`default_nettype wire

/* mips_core.sv */
`timescale 1ns/100ps
`default_nettype none

module mips_core (
    input  wire                      clk_i,
    input  wire                      rst_n_i,
    input  wire                      inst_valid_i,
    input  wire mips_pkg::word_t     inst_i,
    output logic                     wb_we_o,
    output mips_pkg::reg_addr_t      wb_waddr_o,
    output mips_pkg::word_t          wb_wdata_o
);
    import mips_pkg::*;

    logic      dec_rd1_en;
    logic      dec_rd2_en;
    reg_addr_t dec_rd1_addr;
    reg_addr_t dec_rd2_addr;
    alu_op_e   dec_alu_op;
    alu_sel_e  dec_alu_sel;
    reg_addr_t dec_dest;
    logic      dec_wreg;
    word_t     dec_imm;
    word_t     rf_rd1;
    word_t     rf_rd2;
    word_t     op1;
    word_t     op2;
    logic      ex_we;
    reg_addr_t ex_waddr;
    word_t     ex_wdata;

    inst_decoder u_inst_decoder (
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .rd1_en_o     (dec_rd1_en),
        .rd2_en_o     (dec_rd2_en),
        .rd1_addr_o   (dec_rd1_addr),
        .rd2_addr_o   (dec_rd2_addr),
        .alu_op_o     (dec_alu_op),
        .alu_sel_o    (dec_alu_sel),
        .dest_o       (dec_dest),
        .wreg_o       (dec_wreg),
        .imm_o        (dec_imm)
    );

    // written from the memory stage, one cycle after wb appears
    reg_file u_reg_file (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .we_i     (wb_we_o),
        .waddr_i  (wb_waddr_o),
        .wdata_i  (wb_wdata_o),
        .raddr1_i (dec_rd1_addr),
        .raddr2_i (dec_rd2_addr),
        .rdata1_o (rf_rd1),
        .rdata2_o (rf_rd2)
    );

    operand_forward u_operand_forward (
        .rd1_en_i    (dec_rd1_en),
        .rd2_en_i    (dec_rd2_en),
        .rd1_addr_i  (dec_rd1_addr),
        .rd2_addr_i  (dec_rd2_addr),
        .rf_rd1_i    (rf_rd1),
        .rf_rd2_i    (rf_rd2),
        .imm_i       (dec_imm),
        .ex_we_i     (ex_we),
        .ex_waddr_i  (ex_waddr),
        .ex_wdata_i  (ex_wdata),
        .mem_we_i    (wb_we_o),
        .mem_waddr_i (wb_waddr_o),
        .mem_wdata_i (wb_wdata_o),
        .op1_o       (op1),
        .op2_o       (op2)
    );

    exec_stage u_exec_stage (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .wreg_i      (dec_wreg),
        .dest_i      (dec_dest),
        .alu_op_i    (dec_alu_op),
        .alu_sel_i   (dec_alu_sel),
        .op1_i       (op1),
        .op2_i       (op2),
        .ex_we_o     (ex_we),
        .ex_waddr_o  (ex_waddr),
        .ex_wdata_o  (ex_wdata),
        .mem_we_o    (wb_we_o),
        .mem_waddr_o (wb_waddr_o),
        .mem_wdata_o (wb_wdata_o)
    );

endmodule

`default_nettype wire

/* exec_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module exec_stage (
    input  wire                      clk_i,
    input  wire                      rst_n_i,
    input  wire                      wreg_i,
    input  wire mips_pkg::reg_addr_t dest_i,
    input  wire mips_pkg::alu_op_e   alu_op_i,
    input  wire mips_pkg::alu_sel_e  alu_sel_i,
    input  wire mips_pkg::word_t     op1_i,
    input  wire mips_pkg::word_t     op2_i,
    output logic                     ex_we_o,
    output mips_pkg::reg_addr_t      ex_waddr_o,
    output mips_pkg::word_t          ex_wdata_o,
    output logic                     mem_we_o,
    output mips_pkg::reg_addr_t      mem_waddr_o,
    output mips_pkg::word_t          mem_wdata_o
);
    import mips_pkg::*;

    logic      ex_wreg;
    reg_addr_t ex_dest;
    alu_op_e   ex_alu_op;
    alu_sel_e  ex_alu_sel;
    word_t     ex_op1;
    word_t     ex_op2;
    word_t     alu_result;

    // decode -> execute
    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            ex_wreg    <= 1'b0;
            ex_dest    <= REG_ZERO;
            ex_alu_op  <= ALU_NOP;
            ex_alu_sel <= SEL_NONE;
        end
        else
        begin
            ex_wreg    <= wreg_i;
            ex_dest    <= dest_i;
            ex_alu_op  <= alu_op_i;
            ex_alu_sel <= alu_sel_i;
        end
    end

    always_ff @(posedge clk_i)
    begin
        ex_op1 <= op1_i;
        ex_op2 <= op2_i;
    end

    alu u_alu (
        .alu_op_i  (ex_alu_op),
        .alu_sel_i (ex_alu_sel),
        .op1_i     (ex_op1),
        .op2_i     (ex_op2),
        .result_o  (alu_result)
    );

    assign ex_we_o    = ex_wreg;
    assign ex_waddr_o = ex_dest;
    assign ex_wdata_o = alu_result;                   // forwarded same cycle

    // execute -> memory, also the writeback port
    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            mem_we_o    <= 1'b0;
            mem_waddr_o <= REG_ZERO;
        end
        else
        begin
            mem_we_o    <= ex_wreg;
            mem_waddr_o <= ex_dest;
        end
    end

    always_ff @(posedge clk_i)
    begin
        mem_wdata_o <= alu_result;
    end

endmodule

`default_nettype wire

/* alu.sv */
`timescale 1ns/100ps
`default_nettype none

module alu (
    input  wire mips_pkg::alu_op_e  alu_op_i,
    input  wire mips_pkg::alu_sel_e alu_sel_i,
    input  wire mips_pkg::word_t    op1_i,
    input  wire mips_pkg::word_t    op2_i,
    output mips_pkg::word_t         result_o
);
    import mips_pkg::*;

    word_t      logic_res;
    word_t      shift_res;
    word_t      arith_res;
    logic [4:0] sh_amt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign sh_amt      = op1_i[4:0];                  // shamt or rs[4:0]
    assign lt_signed   = $signed(op1_i) < $signed(op2_i);
    assign lt_unsigned = op1_i < op2_i;

    always_comb
    begin
        case (alu_op_i)
            ALU_OR:  logic_res = op1_i | op2_i;
            ALU_AND: logic_res = op1_i & op2_i;
            ALU_XOR: logic_res = op1_i ^ op2_i;
            ALU_NOR: logic_res = ~(op1_i | op2_i);
            default: logic_res = ZERO_WORD;
        endcase
    end

    always_comb
    begin
        case (alu_op_i)
            ALU_SLL: shift_res = op2_i << sh_amt;
            ALU_SRL: shift_res = op2_i >> sh_amt;
            ALU_SRA: shift_res = word_t'($signed(op2_i) >>> sh_amt);   // sign fill
            default: shift_res = ZERO_WORD;
        endcase
    end

    always_comb
    begin
        case (alu_op_i)
            ALU_ADD:  arith_res = op1_i + op2_i;
            ALU_SUB:  arith_res = op1_i + (~op2_i) + 1'b1;
            ALU_SLT:  arith_res = {{(XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU: arith_res = {{(XLEN-1){1'b0}}, lt_unsigned};
            default:  arith_res = ZERO_WORD;
        endcase
    end

    always_comb
    begin
        case (alu_sel_i)
            SEL_LOGIC: result_o = logic_res;
            SEL_SHIFT: result_o = shift_res;
            SEL_ARITH: result_o = arith_res;
            default:   result_o = ZERO_WORD;
        endcase
    end

endmodule

`default_nettype wire

/* reg_file.sv */
`timescale 1ns/100ps
`default_nettype none

module reg_file (
    input  wire                      clk_i,
    input  wire                      rst_n_i,
    input  wire                      we_i,
    input  wire mips_pkg::reg_addr_t waddr_i,
    input  wire mips_pkg::word_t     wdata_i,
    input  wire mips_pkg::reg_addr_t raddr1_i,
    input  wire mips_pkg::reg_addr_t raddr2_i,
    output mips_pkg::word_t          rdata1_o,
    output mips_pkg::word_t          rdata2_o
);
    import mips_pkg::*;

    word_t regs [1:NUM_REGS-1];                       // no storage for r0

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            for (int i = 1; i < NUM_REGS; i++)
            begin
                regs[i] <= ZERO_WORD;
            end
        end
        else if (we_i && (waddr_i != REG_ZERO))
        begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // no write-through, memory-stage forward covers it
    assign rdata1_o = (raddr1_i == REG_ZERO) ? ZERO_WORD : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == REG_ZERO) ? ZERO_WORD : regs[raddr2_i];

endmodule

`default_nettype wire

/* operand_forward.sv */
`timescale 1ns/100ps
`default_nettype none

module operand_forward (
    input  wire                      rd1_en_i,
    input  wire                      rd2_en_i,
    input  wire mips_pkg::reg_addr_t rd1_addr_i,
    input  wire mips_pkg::reg_addr_t rd2_addr_i,
    input  wire mips_pkg::word_t     rf_rd1_i,
    input  wire mips_pkg::word_t     rf_rd2_i,
    input  wire mips_pkg::word_t     imm_i,
    input  wire                      ex_we_i,
    input  wire mips_pkg::reg_addr_t ex_waddr_i,
    input  wire mips_pkg::word_t     ex_wdata_i,
    input  wire                      mem_we_i,
    input  wire mips_pkg::reg_addr_t mem_waddr_i,
    input  wire mips_pkg::word_t     mem_wdata_i,
    output mips_pkg::word_t          op1_o,
    output mips_pkg::word_t          op2_o
);
    import mips_pkg::*;

    // newest producer wins: execute, then memory, then register file
    function automatic word_t pick_operand(input logic en, input reg_addr_t addr,
                                           input word_t rf_data);
        if (!en)
            return imm_i;
        if (ex_we_i && (ex_waddr_i == addr))
            return ex_wdata_i;
        if (mem_we_i && (mem_waddr_i == addr))
            return mem_wdata_i;
        return rf_data;
    endfunction

    always_comb
    begin
        op1_o = pick_operand(rd1_en_i, rd1_addr_i, rf_rd1_i);
        op2_o = pick_operand(rd2_en_i, rd2_addr_i, rf_rd2_i);   // own flag, not rd1
    end

endmodule

`default_nettype wire

/* inst_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module inst_decoder (
    input  wire                      inst_valid_i,
    input  wire mips_pkg::word_t     inst_i,
    output logic                     rd1_en_o,
    output logic                     rd2_en_o,
    output mips_pkg::reg_addr_t      rd1_addr_o,
    output mips_pkg::reg_addr_t      rd2_addr_o,
    output mips_pkg::alu_op_e        alu_op_o,
    output mips_pkg::alu_sel_e       alu_sel_o,
    output mips_pkg::reg_addr_t      dest_o,
    output logic                     wreg_o,
    output mips_pkg::word_t          imm_o
);
    import mips_pkg::*;

    opcode_e          op;
    funct_e           funct;
    logic [4:0]       shamt;
    reg_addr_t        rs;
    reg_addr_t        rt;
    reg_addr_t        rd;
    logic [IMM_W-1:0] imm16;
    logic             const_shift;
    logic             kept;

    assign op    = opcode_e'(inst_i[31:26]);
    assign rs    = inst_i[25:21];
    assign rt    = inst_i[20:16];
    assign rd    = inst_i[15:11];
    assign shamt = inst_i[10:6];
    assign funct = funct_e'(inst_i[5:0]);
    assign imm16 = inst_i[IMM_W-1:0];

    // sll/srl/sra with rs field zero
    assign const_shift = (inst_i[31:21] == 11'd0) && (funct inside {FN_SLL, FN_SRL, FN_SRA});

    assign rd1_addr_o = rs;
    assign rd2_addr_o = rt;

    always_comb
    begin
        alu_op_o = ALU_NOP;
        rd1_en_o = 1'b0;
        rd2_en_o = 1'b0;
        dest_o   = rt;                                // immediate forms write rt
        imm_o    = ZERO_WORD;

        case (op)
            OP_SPECIAL:
            begin
                rd1_en_o = 1'b1;
                rd2_en_o = 1'b1;
                dest_o   = rd;
                if (const_shift)
                begin
                    rd1_en_o = 1'b0;                  // shamt goes in as operand 1
                    imm_o    = {{(XLEN-5){1'b0}}, shamt};
                    case (funct)
                        FN_SLL:  alu_op_o = ALU_SLL;
                        FN_SRL:  alu_op_o = ALU_SRL;
                        default: alu_op_o = ALU_SRA;
                    endcase
                end
                else if (shamt == 5'd0)
                begin
                    case (funct)
                        FN_OR:   alu_op_o = ALU_OR;
                        FN_AND:  alu_op_o = ALU_AND;
                        FN_XOR:  alu_op_o = ALU_XOR;
                        FN_NOR:  alu_op_o = ALU_NOR;
                        FN_SLLV: alu_op_o = ALU_SLL;
                        FN_SRLV: alu_op_o = ALU_SRL;
                        FN_SRAV: alu_op_o = ALU_SRA;
                        FN_ADD,
                        FN_ADDU: alu_op_o = ALU_ADD;  // no overflow trap
                        FN_SUB,
                        FN_SUBU: alu_op_o = ALU_SUB;
                        FN_SLT:  alu_op_o = ALU_SLT;
                        FN_SLTU: alu_op_o = ALU_SLTU;
                        default: alu_op_o = ALU_NOP;
                    endcase
                end
            end
            OP_ORI, OP_ANDI, OP_XORI:
            begin
                rd1_en_o = 1'b1;
                imm_o    = {{(XLEN-IMM_W){1'b0}}, imm16};
                case (op)
                    OP_ORI:  alu_op_o = ALU_OR;
                    OP_ANDI: alu_op_o = ALU_AND;
                    default: alu_op_o = ALU_XOR;
                endcase
            end
            OP_LUI:
            begin
                rd1_en_o = 1'b1;                      // or'ed with rs
                imm_o    = {imm16, {(XLEN-IMM_W){1'b0}}};
                alu_op_o = ALU_OR;
            end
            OP_SLTI, OP_SLTIU, OP_ADDI, OP_ADDIU:
            begin
                rd1_en_o = 1'b1;
                imm_o    = {{(XLEN-IMM_W){imm16[IMM_W-1]}}, imm16};
                case (op)
                    OP_SLTI:  alu_op_o = ALU_SLT;
                    OP_SLTIU: alu_op_o = ALU_SLTU;   // still sign extended
                    default:  alu_op_o = ALU_ADD;
                endcase
            end
            default:
            begin
                alu_op_o = ALU_NOP;                   // dropped or unknown
            end
        endcase
    end

    always_comb
    begin
        case (alu_op_o)
            ALU_OR, ALU_AND, ALU_XOR, ALU_NOR:    alu_sel_o = SEL_LOGIC;
            ALU_SLL, ALU_SRL, ALU_SRA:            alu_sel_o = SEL_SHIFT;
            ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU:  alu_sel_o = SEL_ARITH;
            default:                              alu_sel_o = SEL_NONE;
        endcase
    end

    assign kept   = (alu_op_o != ALU_NOP);
    assign wreg_o = inst_valid_i && kept && (dest_o != REG_ZERO);   // r0 never written

endmodule

`default_nettype wire

/* mips_pkg.sv */
`default_nettype none

package mips_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 2 ** REG_ADDR_W;
    localparam int IMM_W      = 16;                   // I-type immediate field

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    localparam word_t     ZERO_WORD = '0;
    localparam reg_addr_t REG_ZERO  = '0;             // r0, hardwired zero

    // primary opcode, inst[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,
        OP_ADDI    = 6'b001000,
        OP_ADDIU   = 6'b001001,
        OP_SLTI    = 6'b001010,
        OP_SLTIU   = 6'b001011,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111
    } opcode_e;

    // SPECIAL function code, inst[5:0]
    typedef enum logic [5:0] {
        FN_SLL  = 6'b000000,
        FN_SRL  = 6'b000010,
        FN_SRA  = 6'b000011,
        FN_SLLV = 6'b000100,
        FN_SRLV = 6'b000110,
        FN_SRAV = 6'b000111,
        FN_ADD  = 6'b100000,
        FN_ADDU = 6'b100001,
        FN_SUB  = 6'b100010,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_NOR  = 6'b100111,
        FN_SLT  = 6'b101010,
        FN_SLTU = 6'b101011
    } funct_e;

    typedef enum logic [3:0] {
        ALU_NOP, ALU_OR, ALU_AND, ALU_XOR, ALU_NOR,
        ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU
    } alu_op_e;

    typedef enum logic [1:0] {
        SEL_NONE, SEL_LOGIC, SEL_SHIFT, SEL_ARITH
    } alu_sel_e;

endpackage

`default_nettype wire
